// File: testbench/instruction_testdata.txt
# Columns: instruction word (hex), expected state number (decimal)
# One vector per line, driven one per clock cycle
E5C12004 20
E5D12004 66
E5412004 30
E5512004 74
E5812004 43
E5912004 85
E5012004 53
E5112004 93
E5212004 55
E5712004 76
E5B12004 87
E4912004 89
E4E12004 24
E4112004 97
E7C12003 21
E7112003 94
E7712003 76
E7A12003 46
E7F12003 69
E6C12003 27
E6B12003 91
E7912013 1
E1C120B4 104
E1C120D4 184
E1C120F4 207
E1D120B4 127
E1D120D4 146
E1D120F4 165
E15120B4 135
E14120F4 217
E1F120D4 148
E1E120B4 106
E17120F4 175
E0C120D4 188
E0F120B4 131
E04120B4 118
E05120F4 177
E0012093 1
E18120B3 105
E19120F3 166
E10120D3 193
E11120D3 155
E1A120F3 210
E1B120B3 130
E13120F3 176
E12120B3 117
E09120D3 152
E08120F3 214
E01120B3 141
E00120D3 198
E0112093 1
E0812003 11
E0912003 10
E3A02005 11
E3B02005 10
E1512003 14
E3112001 14
E1312003 14
E3712001 14
E0812113 11
EC812000 1
EA000010 12
EB000010 13
E8810006 234
E8910006 247
EE012000 1
E9210006 239
E9910006 252
E8110006 247
EF000000 1

// File: filelist.f
hw/arm_decode_pkg.sv
hw/instruction_classifier.sv
hw/single_transfer_decoder.sv
hw/misc_transfer_decoder.sv
hw/data_branch_block_decoder.sv
hw/instruction_state_encoder.sv
testbench/tb_instruction_state_encoder.sv

// File: testbench/tb_instruction_state_encoder.sv
`timescale 1ns/1ns

module tb_instruction_state_encoder;

    localparam int TIMEOUT_CYCLES = 20;
    localparam int RESET_CYCLES   = 8;

    logic                   clk;
    logic                   reset;
    logic [31:0]            instruction;
    arm_decode_pkg::state_t state_number;

    logic [31:0]            vec_instr [$];
    arm_decode_pkg::state_t vec_expected [$];
    logic [31:0]            sent_instr [$];       // Driven, result not yet checked
    arm_decode_pkg::state_t sent_expected [$];

    int error_count;
    int check_count;

    instruction_state_encoder i_dut
    (
        .clk          (clk),
        .reset        (reset),
        .instruction  (instruction),
        .state_number (state_number)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    task automatic read_vectors();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] word;
        int          value;
        fd = $fopen("testbench/instruction_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the vector file testbench/instruction_testdata.txt");
            error_count++;
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            fields = $sscanf(line, "%h %d", word, value);
            if (fields == 2)    // Header and blank lines fall through
            begin
                vec_instr.push_back(word);
                vec_expected.push_back(arm_decode_pkg::state_t'(value));
            end
        end
        $fclose(fd);
    endtask

    task automatic check_value(input arm_decode_pkg::state_t expected,
                               input logic [31:0]            instr);
        check_count++;
        assert (state_number === expected)
        else
        begin
            error_count++;
            $display("error at %0t ns: state_number for instruction %h expected %0d, got %0d",
                     $time, instr, expected, state_number);
        end
    endtask

    task automatic check_oldest();
        logic [31:0]            instr;
        arm_decode_pkg::state_t expected;
        instr    = sent_instr.pop_front();
        expected = sent_expected.pop_front();
        check_value(expected, instr);
    endtask

    initial
    begin
        int cycles;
        error_count = 0;
        check_count = 0;
        reset       = 1'b1;
        instruction = '0;

        read_vectors();
        if (vec_instr.size() == 0)
        begin
            $display("No vectors were read from the data file");
            error_count++;
        end

        // Register must hold fetch for the whole reset
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            @(posedge clk);
            reset <= 1'b1;
            @(negedge clk);
            check_value(arm_decode_pkg::STATE_FETCH, instruction);
        end
        @(posedge clk);
        reset <= 1'b0;

        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (reset !== 1'b0 && cycles < TIMEOUT_CYCLES);
        if (reset !== 1'b0)
        begin
            $display("Reset was not released within %0d cycles", TIMEOUT_CYCLES);
            error_count++;
        end
        else
            check_value(arm_decode_pkg::STATE_FETCH, instruction);    // Still fetch

        // One vector per cycle, result checked a cycle later
        for (int k = 0; k < vec_instr.size(); k++)
        begin
            @(posedge clk);
            instruction <= vec_instr[k];
            sent_instr.push_back(vec_instr[k]);
            sent_expected.push_back(vec_expected[k]);
            @(negedge clk);
            if (sent_expected.size() > 1)
                check_oldest();
        end

        cycles = 0;
        while (sent_expected.size() > 0 && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            check_oldest();
            cycles++;
        end
        if (sent_expected.size() > 0)
        begin
            $display("Last results were not checked within %0d cycles", TIMEOUT_CYCLES);
            error_count++;
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: hw/instruction_state_encoder.sv
`timescale 1ns/1ns

module instruction_state_encoder
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [31:0]            instruction,
    output arm_decode_pkg::state_t state_number
);

    arm_decode_pkg::instr_class_t instr_class;
    arm_decode_pkg::state_t       single_state;
    arm_decode_pkg::state_t       misc_state;
    arm_decode_pkg::state_t       simple_state;
    arm_decode_pkg::state_t       next_state;
    logic                         misc_known;

    instruction_classifier i_classifier
    (
        .instruction (instruction),
        .instr_class (instr_class)
    );

    single_transfer_decoder i_single
    (
        .instruction (instruction),
        .state       (single_state)
    );

    misc_transfer_decoder i_misc
    (
        .instruction (instruction),
        .state       (misc_state),
        .misc_known  (misc_known)
    );

    data_branch_block_decoder i_simple
    (
        .instruction (instruction),
        .instr_class (instr_class),
        .state       (simple_state)
    );

    always_comb
    begin
        case (instr_class)
            arm_decode_pkg::CLASS_SINGLE: next_state = single_state;
            arm_decode_pkg::CLASS_MISC:
                next_state = misc_known ? misc_state : arm_decode_pkg::STATE_FETCH;
            arm_decode_pkg::CLASS_TEST,
            arm_decode_pkg::CLASS_DATA,
            arm_decode_pkg::CLASS_BRANCH,
            arm_decode_pkg::CLASS_BLOCK:  next_state = simple_state;
            default:                      next_state = arm_decode_pkg::STATE_FETCH;
        endcase
    end

    // Feeds the control unit state register
    always_ff @(posedge clk)
    begin
        if (reset)
            state_number <= arm_decode_pkg::STATE_FETCH;
        else
            state_number <= next_state;
    end

    // State 0 is not a valid microcode entry
    a_never_zero: assert property (@(posedge clk) disable iff (reset)
        state_number != '0);

    a_unknown_fetch: assert property (@(posedge clk) disable iff (reset)
        instr_class == arm_decode_pkg::CLASS_UNKNOWN |=>
            state_number == arm_decode_pkg::STATE_FETCH);

endmodule

// File: hw/data_branch_block_decoder.sv
`timescale 1ns/1ns

module data_branch_block_decoder
(
    input  logic [31:0]                  instruction,
    input  arm_decode_pkg::instr_class_t instr_class,
    output arm_decode_pkg::state_t       state
);

    logic [1:0] block_sel;

    assign block_sel = {instruction[arm_decode_pkg::BIT_P], instruction[arm_decode_pkg::BIT_L]};

    always_comb
    begin
        case (instr_class)
            arm_decode_pkg::CLASS_TEST:
                state = arm_decode_pkg::STATE_TEST;
            arm_decode_pkg::CLASS_DATA:
            begin
                if (instruction[arm_decode_pkg::BIT_S])
                    state = arm_decode_pkg::STATE_DP_S;    // Flags updated
                else
                    state = arm_decode_pkg::STATE_DP;
            end
            arm_decode_pkg::CLASS_BRANCH:
            begin
                // Link bit shares position with P
                if (instruction[arm_decode_pkg::BIT_P])
                    state = arm_decode_pkg::STATE_BL;
                else
                    state = arm_decode_pkg::STATE_B;
            end
            arm_decode_pkg::CLASS_BLOCK:
            begin
                case (block_sel)
                    2'b00:   state = arm_decode_pkg::STATE_STM_IA;
                    2'b01:   state = arm_decode_pkg::STATE_LDM_IA;
                    2'b10:   state = arm_decode_pkg::STATE_STM_IB;
                    default: state = arm_decode_pkg::STATE_LDM_IB;
                endcase
            end
            default:
                state = arm_decode_pkg::STATE_FETCH;
        endcase
    end

endmodule

// File: hw/misc_transfer_decoder.sv
`timescale 1ns/1ns

// Halfword, signed byte/halfword and doubleword transfers
module misc_transfer_decoder
(
    input  logic [31:0]           instruction,
    output arm_decode_pkg::state_t state,
    output logic                  misc_known
);

    logic [2:0] lsh;
    logic [2:0] access;     // Column in MISC_TABLE
    logic       reg_form;   // Bit 22 clear for register offset
    logic [1:0] mode;
    logic       is_sub;
    logic [6:0] idx;

    assign lsh = {instruction[arm_decode_pkg::BIT_L], instruction[6], instruction[5]};

    always_comb
    begin
        access     = 3'd0;
        misc_known = 1'b1;
        case (lsh)
            3'b001: access = 3'd0;    // STRH
            3'b010: access = 3'd1;    // LDRD
            3'b011: access = 3'd2;    // STRD
            3'b101: access = 3'd3;    // LDRH
            3'b110: access = 3'd4;    // LDRSB
            3'b111: access = 3'd5;    // LDRSH
            default:
            begin
                // 000 is SWP/MUL space and 100 has no handler
                misc_known = 1'b0;
            end
        endcase
    end

    assign reg_form = !instruction[arm_decode_pkg::BIT_B];
    assign mode     = arm_decode_pkg::addr_mode(instruction[arm_decode_pkg::BIT_P],
                                                instruction[arm_decode_pkg::BIT_W]);
    assign is_sub   = !instruction[arm_decode_pkg::BIT_U];

    // 36 per offset form, 12 per mode, 6 per direction
    always_comb
    begin
        idx = 7'd0;
        if (reg_form)
            idx = idx + 7'd36;
        case (mode)
            2'd1:    idx = idx + 7'd12;
            2'd2:    idx = idx + 7'd24;
            default: idx = idx;
        endcase
        if (is_sub)
            idx = idx + 7'd6;
        idx = idx + {4'b0000, access};
    end

    // Only valid while misc_known is high
    assign state = arm_decode_pkg::MISC_TABLE[idx];

endmodule

// File: hw/single_transfer_decoder.sv
`timescale 1ns/1ns

// Word and unsigned byte LDR/STR. Class is checked by the caller.
module single_transfer_decoder
(
    input  logic [31:0]           instruction,
    output arm_decode_pkg::state_t state
);

    logic       reg_offset;    // Bit 25 set for register offset
    logic [1:0] mode;
    logic       is_word;
    logic       is_sub;
    logic       is_load;
    logic [5:0] idx;

    assign reg_offset = instruction[arm_decode_pkg::TYPE_LO];

    assign mode = arm_decode_pkg::addr_mode(instruction[arm_decode_pkg::BIT_P],
                                            instruction[arm_decode_pkg::BIT_W]);

    // Byte entries come first in each row
    assign is_word = !instruction[arm_decode_pkg::BIT_B];
    assign is_sub  = !instruction[arm_decode_pkg::BIT_U];    // Add first
    assign is_load = instruction[arm_decode_pkg::BIT_L];

    // 24 entries per offset kind, 8 per addressing mode
    always_comb
    begin
        idx = 6'd0;
        if (reg_offset)
            idx = idx + 6'd24;
        idx = idx + {1'b0, mode, 3'b000};
        idx = idx + {3'b000, is_word, is_sub, is_load};
    end

    assign state = arm_decode_pkg::SINGLE_TABLE[idx];

endmodule

// File: hw/instruction_classifier.sv
`timescale 1ns/1ns

module instruction_classifier
(
    input  logic [31:0]                 instruction,
    output arm_decode_pkg::instr_class_t instr_class
);

    logic [2:0] itype;
    logic [3:0] opcode;
    logic       is_dp;

    assign itype  = instruction[arm_decode_pkg::TYPE_HI:arm_decode_pkg::TYPE_LO];
    assign opcode = instruction[arm_decode_pkg::OPC_HI:arm_decode_pkg::OPC_LO];
    assign is_dp  = (itype == arm_decode_pkg::TYPE_DP_REG) ||
                    (itype == arm_decode_pkg::TYPE_DP_IMM);

    // First match wins
    always_comb
    begin
        if ((itype == arm_decode_pkg::TYPE_LS_IMM) ||
            (itype == arm_decode_pkg::TYPE_LS_REG && !instruction[arm_decode_pkg::BIT_REG4]))
            instr_class = arm_decode_pkg::CLASS_SINGLE;
        else if (itype == arm_decode_pkg::TYPE_DP_REG &&
                 instruction[arm_decode_pkg::BIT_MISC7] &&
                 instruction[arm_decode_pkg::BIT_REG4])
            instr_class = arm_decode_pkg::CLASS_MISC;    // Halfword space inside DP
        else if (is_dp && opcode[3:2] == 2'b10)
            instr_class = arm_decode_pkg::CLASS_TEST;    // TST, TEQ, CMP, CMN
        else if (is_dp)
            instr_class = arm_decode_pkg::CLASS_DATA;
        else if (itype == arm_decode_pkg::TYPE_BRANCH)
            instr_class = arm_decode_pkg::CLASS_BRANCH;
        else if (itype == arm_decode_pkg::TYPE_BLOCK)
            instr_class = arm_decode_pkg::CLASS_BLOCK;
        else
            instr_class = arm_decode_pkg::CLASS_UNKNOWN;
    end

endmodule

// File: hw/arm_decode_pkg.sv
package arm_decode_pkg;

    localparam int STATE_W = 10;

    typedef logic [STATE_W-1:0] state_t;    // Microcode state number

    typedef enum logic [2:0]
    {
        CLASS_SINGLE,
        CLASS_MISC,
        CLASS_TEST,
        CLASS_DATA,
        CLASS_BRANCH,
        CLASS_BLOCK,
        CLASS_UNKNOWN
    } instr_class_t;

    // Instruction bit positions
    localparam int BIT_P     = 24;    // Pre/post index
    localparam int BIT_U     = 23;    // Add/subtract offset
    localparam int BIT_B     = 22;    // Byte, or immediate for halfwords
    localparam int BIT_W     = 21;    // Writeback
    localparam int BIT_L     = 20;    // Load/store
    localparam int BIT_S     = 20;    // Set flags
    localparam int BIT_REG4  = 4;
    localparam int BIT_MISC7 = 7;

    localparam int OPC_HI  = 24;
    localparam int OPC_LO  = 21;
    localparam int TYPE_HI = 27;
    localparam int TYPE_LO = 25;

    localparam logic [2:0] TYPE_DP_REG = 3'b000;
    localparam logic [2:0] TYPE_DP_IMM = 3'b001;
    localparam logic [2:0] TYPE_LS_IMM = 3'b010;
    localparam logic [2:0] TYPE_LS_REG = 3'b011;
    localparam logic [2:0] TYPE_BLOCK  = 3'b100;
    localparam logic [2:0] TYPE_BRANCH = 3'b101;

    localparam state_t STATE_FETCH  = 1;
    localparam state_t STATE_DP_S   = 10;
    localparam state_t STATE_DP     = 11;
    localparam state_t STATE_B      = 12;
    localparam state_t STATE_BL     = 13;
    localparam state_t STATE_TEST   = 14;
    localparam state_t STATE_STM_IA = 234;    // Inc/dec after
    localparam state_t STATE_LDM_IA = 247;
    localparam state_t STATE_STM_IB = 239;    // Inc/dec before
    localparam state_t STATE_LDM_IB = 252;

    // Row order: byte add, byte sub, word add, word sub; store then load
    localparam state_t SINGLE_TABLE [48] = '{
        20, 66, 30, 74, 43, 85, 53, 93,    // Immediate, offset
        22, 68, 32, 76, 45, 87, 55, 95,    // Immediate, pre-indexed
        24, 70, 34, 78, 47, 89, 57, 97,    // Immediate, post-indexed
        21, 67, 31, 75, 44, 86, 54, 94,    // Register, offset
        23, 69, 33, 76, 46, 88, 56, 96,    // Register, pre-indexed (76 repeats)
        27, 72, 37, 80, 50, 91, 60, 99     // Register, post-indexed
    };

    // Columns: STRH, LDRD, STRD, LDRH, LDRSB, LDRSH
    localparam state_t MISC_TABLE [72] = '{
        104, 184, 207, 127, 146, 165,    // Immediate, offset, add
        114, 192, 217, 135, 154, 173,    // Immediate, offset, subtract
        106, 186, 209, 129, 148, 167,    // Immediate, pre-indexed, add
        116, 194, 219, 137, 156, 175,
        108, 188, 211, 131, 150, 169,    // Immediate, post-indexed, add
        118, 196, 221, 139, 158, 177,
        105, 185, 208, 128, 147, 166,    // Register, offset, add
        115, 193, 218, 136, 155, 174,
        107, 187, 210, 130, 149, 168,    // Register, pre-indexed, add
        117, 195, 220, 138, 157, 176,
        111, 190, 214, 133, 152, 171,    // Register, post-indexed, add
        121, 198, 224, 141, 160, 179
    };

    // 0 offset, 1 pre-indexed, 2 post-indexed
    function automatic logic [1:0] addr_mode(input logic p, input logic w);
        if (!p)
            return 2'd2;    // W has no effect when post-indexed
        return w ? 2'd1 : 2'd0;
    endfunction

endpackage
